//--- verilog/ln_pkg.sv
package ln_pkg;

    // Vector geometry
    localparam int VEC_LEN  = 8;
    localparam int LOG2_LEN = 3;

    // Q4.4 element format
    localparam int ELEM_W = 8;
    localparam int FRAC_W = 4;

    // Scaled deviation N*x_i - S_x, range is about +/-1785
    localparam int DEV_W = 12;

    // Sum of eight squared deviations, unsigned
    localparam int SUMSQ_W = 25;

    // Q >> 3*log2(N) gives the variance code
    localparam int VAR_SHIFT = 9;
    localparam int VAR_W     = 16;

    // Integer standard deviation, one result bit per root iteration
    localparam int SD_W = 8;

    // Load edge to registered sum of squares
    localparam int STATS_CYCLES = 2;

    typedef logic signed [ELEM_W-1:0] elem_t;
    typedef elem_t [VEC_LEN-1:0] vec_t;

    typedef logic signed [DEV_W-1:0] dev_t;
    typedef dev_t [VEC_LEN-1:0] dev_vec_t;

    typedef logic [SUMSQ_W-1:0] sumsq_t;
    typedef logic [SD_W-1:0] sd_t;

    // Input stream payload, gamma and beta travel with the data
    typedef struct packed {
        vec_t data;
        vec_t gamma;
        vec_t beta;
    } ln_in_t;

    // Per-element affine coefficients held for the last stage
    typedef struct packed {
        vec_t gamma;
        vec_t beta;
    } ln_coef_t;

endpackage

//--- verilog/layer_norm_ctrl.sv
`timescale 1ns/1ps

module layer_norm_ctrl import ln_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  logic out_ready,
    input  logic sqrt_done,
    output logic in_ready,
    output logic out_valid,
    output logic stats_load,
    output logic sqrt_start,
    output logic affine_load
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_STATS,
        ST_ROOT,
        ST_AFFINE,
        ST_HOLD
    } state_t;

    localparam int CNT_W = $clog2(STATS_CYCLES + 1);

    state_t state;
    state_t state_nxt;
    logic [CNT_W-1:0] stats_cnt;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state     <= ST_IDLE;
            stats_cnt <= '0;
        end
        else
        begin
            state <= state_nxt;
            // Counts the fixed statistics latency, idles at zero elsewhere
            if (state == ST_STATS)
                stats_cnt <= stats_cnt + 1'b1;
            else
                stats_cnt <= '0;
        end
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
            begin
                if (in_valid)
                    state_nxt = ST_STATS;
            end
            ST_STATS:
            begin
                if (stats_cnt == CNT_W'(STATS_CYCLES))
                    state_nxt = ST_ROOT;
            end
            ST_ROOT:
            begin
                if (sqrt_done)
                    state_nxt = ST_AFFINE;
            end
            // First cycle the result is offered
            ST_AFFINE:
            begin
                state_nxt = out_ready ? ST_IDLE : ST_HOLD;
            end
            ST_HOLD:
            begin
                if (out_ready)
                    state_nxt = ST_IDLE;
            end
            default:
            begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    assign in_ready    = (state == ST_IDLE);
    assign stats_load  = in_ready && in_valid;
    // Sum of squares is registered by now, the root samples it on this edge
    assign sqrt_start  = (state == ST_STATS) && (stats_cnt == CNT_W'(STATS_CYCLES));
    assign affine_load = (state == ST_ROOT) && sqrt_done;
    assign out_valid   = (state == ST_AFFINE) || (state == ST_HOLD);

endmodule

//--- verilog/norm_stats.sv
`timescale 1ns/1ps

module norm_stats import ln_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  ln_in_t   in_data,
    output dev_vec_t dev,
    output ln_coef_t coef,
    output sumsq_t   sum_sq
);

    ln_in_t   in_r;
    dev_vec_t dev_c;
    dev_vec_t dev_r;
    sumsq_t   sq_acc;
    sumsq_t   sum_sq_r;
    logic [1:0] stage_v;

    always_ff @(posedge clk)
    begin
        if (load)
            in_r <= in_data;
    end

    // Stage strobes follow the load through the two datapath registers
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            stage_v <= '0;
        else
            stage_v <= {stage_v[0], load};
    end

    // Widened element sum, then d_i = N*x_i - S_x
    always_comb
    begin
        dev_t elem_sum;
        elem_sum = '0;
        for (int i = 0; i < VEC_LEN; i++)
            elem_sum = elem_sum + DEV_W'(in_r.data[i]);
        for (int i = 0; i < VEC_LEN; i++)
            dev_c[i] = (DEV_W'(in_r.data[i]) <<< LOG2_LEN) - elem_sum;
    end

    always_comb
    begin
        logic signed [2*DEV_W-1:0] dev_sq;
        sq_acc = '0;
        for (int i = 0; i < VEC_LEN; i++)
        begin
            dev_sq = dev_r[i] * dev_r[i];
            sq_acc = sq_acc + SUMSQ_W'(dev_sq);
        end
    end

    always_ff @(posedge clk)
    begin
        if (stage_v[0])
            dev_r <= dev_c;
        if (stage_v[1])
            sum_sq_r <= sq_acc;
    end

    assign dev        = dev_r;
    assign coef.gamma = in_r.gamma;
    assign coef.beta  = in_r.beta;
    assign sum_sq     = sum_sq_r;

endmodule

//--- verilog/norm_sqrt.sv
`timescale 1ns/1ps

module norm_sqrt import ln_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start,
    input  sumsq_t sum_sq,
    output logic   done,
    output sd_t    sd
);

    logic [VAR_W-1:0]  var_r;
    sd_t               root_r;
    sd_t               mask_r;
    sd_t               trial;
    logic [2*SD_W-1:0] trial_sq;
    logic              busy;
    logic              done_r;

    // Candidate root with the current bit set
    assign trial    = root_r | mask_r;
    assign trial_sq = trial * trial;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            busy   <= 1'b0;
            mask_r <= '0;
            done_r <= 1'b0;
        end
        else
        begin
            done_r <= busy && mask_r[0];
            if (start)
            begin
                busy   <= 1'b1;
                mask_r <= {1'b1, {(SD_W-1){1'b0}}};
            end
            else if (busy)
            begin
                mask_r <= mask_r >> 1;
                // LSB was tried this cycle
                if (mask_r[0])
                    busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            var_r  <= VAR_W'(sum_sq >> VAR_SHIFT);
            root_r <= '0;
        end
        else if (busy && (trial_sq <= var_r))
        begin
            root_r <= trial;
        end
    end

    assign done = done_r;
    // Epsilon guard, a zero root would divide by zero downstream
    assign sd   = (root_r == '0) ? sd_t'(1) : root_r;

endmodule

//--- verilog/norm_affine.sv
`timescale 1ns/1ps

module norm_affine import ln_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  dev_vec_t dev,
    input  ln_coef_t coef,
    input  sd_t      sd,
    output vec_t     out_data
);

    localparam int WIDE_W = 2*ELEM_W + 1;

    logic signed [SD_W+LOG2_LEN:0] den;
    vec_t y_c;
    vec_t out_r;

    // Clamp to the signed element range, in range when the upper bits agree
    function automatic elem_t sat_elem(input logic signed [WIDE_W-1:0] v);
        if (&v[WIDE_W-1:ELEM_W-1] || ~|v[WIDE_W-1:ELEM_W-1])
            return v[ELEM_W-1:0];
        else if (v[WIDE_W-1])
            return {1'b1, {(ELEM_W-1){1'b0}}};
        else
            return {1'b0, {(ELEM_W-1){1'b1}}};
    endfunction

    // N times sd, always positive
    assign den = $signed({1'b0, sd, {LOG2_LEN{1'b0}}});

    always_comb
    begin
        logic signed [DEV_W+FRAC_W-1:0] num;
        logic signed [DEV_W+FRAC_W-1:0] quot;
        elem_t                          n_elem;
        logic signed [2*ELEM_W-1:0]     prod;
        logic signed [2*ELEM_W-1:0]     prod_sh;
        logic signed [WIDE_W-1:0]       acc;
        for (int i = 0; i < VEC_LEN; i++)
        begin
            num    = (DEV_W+FRAC_W)'(dev[i]) <<< FRAC_W;
            // Signed divide truncates toward zero
            quot   = num / den;
            n_elem = sat_elem(quot);
            prod    = n_elem * coef.gamma[i];
            prod_sh = prod >>> FRAC_W;
            acc     = prod_sh + coef.beta[i];
            y_c[i]  = sat_elem(acc);
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            out_r <= '0;
        else if (load)
            out_r <= y_c;
    end

    assign out_data = out_r;

endmodule

//--- verilog/layer_norm_top.sv
`timescale 1ns/1ps

module layer_norm_top import ln_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  ln_in_t in_data,
    input  logic   out_ready,
    output logic   in_ready,
    output logic   out_valid,
    output vec_t   out_data
);

    logic     stats_load;
    logic     sqrt_start;
    logic     sqrt_done;
    logic     affine_load;
    dev_vec_t dev;
    ln_coef_t coef;
    sumsq_t   sum_sq;
    sd_t      sd;

    layer_norm_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .out_ready   (out_ready),
        .sqrt_done   (sqrt_done),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .stats_load  (stats_load),
        .sqrt_start  (sqrt_start),
        .affine_load (affine_load)
    );

    norm_stats u_stats (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (stats_load),
        .in_data (in_data),
        .dev     (dev),
        .coef    (coef),
        .sum_sq  (sum_sq)
    );

    norm_sqrt u_sqrt (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (sqrt_start),
        .sum_sq (sum_sq),
        .done   (sqrt_done),
        .sd     (sd)
    );

    norm_affine u_affine (
        .clk      (clk),
        .rst_n    (rst_n),
        .load     (affine_load),
        .dev      (dev),
        .coef     (coef),
        .sd       (sd),
        .out_data (out_data)
    );

endmodule

//--- dv/ln_checker.sv
`timescale 1ns/1ps

module ln_checker import ln_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   in_valid,
    input  logic   in_ready,
    input  ln_in_t in_data,
    input  logic   out_valid,
    input  logic   out_ready,
    input  vec_t   out_data,
    output int     checked_count,
    output int     mismatch_count,
    output int     protocol_count
);

    ln_in_t accepted_q[$];
    int     n_checked    = 0;
    int     n_mismatch   = 0;
    int     n_protocol   = 0;
    bit     was_waiting  = 1'b0;
    vec_t   waiting_data = '0;

    assign checked_count  = n_checked;
    assign mismatch_count = n_mismatch;
    assign protocol_count = n_protocol;

    function automatic int clamp_elem(input int v);
        if (v > 127)
            return 127;
        if (v < -128)
            return -128;
        return v;
    endfunction

    function automatic int int_sqrt(input int v);
        int r;
        r = 0;
        while ((r + 1) * (r + 1) <= v)
            r++;
        return r;
    endfunction

    // Expected output vector for one accepted input
    function automatic vec_t ref_layer_norm(input ln_in_t v);
        int   sum;
        int   d[VEC_LEN];
        int   q;
        int   sd;
        int   n;
        int   y;
        vec_t res;
        sum = 0;
        q   = 0;
        for (int i = 0; i < VEC_LEN; i++)
            sum += int'(v.data[i]);
        for (int i = 0; i < VEC_LEN; i++)
        begin
            d[i] = VEC_LEN * int'(v.data[i]) - sum;
            q += d[i] * d[i];
        end
        sd = int_sqrt(q >> (3 * LOG2_LEN));
        // Epsilon guard
        if (sd == 0)
            sd = 1;
        for (int i = 0; i < VEC_LEN; i++)
        begin
            n = clamp_elem((d[i] * (1 << FRAC_W)) / (VEC_LEN * sd));
            y = clamp_elem(((n * int'(v.gamma[i])) >>> FRAC_W) + int'(v.beta[i]));
            res[i] = elem_t'(y);
        end
        return res;
    endfunction

    always @(posedge clk)
    begin
        ln_in_t exp_in;
        vec_t   exp_out;
        if (!rst_n)
            was_waiting = 1'b0;
        else
        begin
            if (in_valid && in_ready)
                accepted_q.push_back(in_data);
            if (out_valid && in_ready)
            begin
                n_protocol++;
                $display("ERROR: in_ready is high while a result waits on the output");
            end
            // A waiting result must stay offered and unchanged
            if (was_waiting && !out_valid)
            begin
                n_protocol++;
                $display("ERROR: out_valid dropped before the output transfer");
            end
            else if (was_waiting && out_data !== waiting_data)
            begin
                n_mismatch++;
                $display("mismatch out_data while held: expected %h actual %h",
                         waiting_data, out_data);
            end
            if (out_valid && out_ready)
            begin
                if (accepted_q.size() == 0)
                begin
                    n_protocol++;
                    $display("ERROR: output transfer with no accepted input pending");
                end
                else
                begin
                    exp_in  = accepted_q.pop_front();
                    exp_out = ref_layer_norm(exp_in);
                    for (int i = 0; i < VEC_LEN; i++)
                    begin
                        if (out_data[i] !== exp_out[i])
                        begin
                            n_mismatch++;
                            $display("mismatch out_data[%0d] result %0d: expected %h actual %h",
                                     i, n_checked, exp_out[i], out_data[i]);
                        end
                    end
                    n_checked++;
                end
            end
            was_waiting  = out_valid && !out_ready;
            waiting_data = out_data;
        end
    end

endmodule

//--- dv/tb_layer_norm.sv
`timescale 1ns/1ps

module tb_layer_norm import ln_pkg::*; ();

    localparam int WAIT_LIMIT = 2000;
    localparam int N_UNIT     = 20;
    localparam int N_AFFINE   = 30;
    localparam int N_CONST    = 6;
    localparam int N_BACKPR   = 30;

    logic   clk;
    logic   rst_n;
    logic   in_valid;
    ln_in_t in_data;
    logic   out_ready;
    logic   in_ready;
    logic   out_valid;
    vec_t   out_data;

    int checked_count;
    int mismatch_count;
    int protocol_count;
    int sent_count;
    int other_errs;
    bit timed_out;
    bit bp_mode;
    int hold_left;

    layer_norm_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    ln_checker u_checker (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_data        (in_data),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .out_data       (out_data),
        .checked_count  (checked_count),
        .mismatch_count (mismatch_count),
        .protocol_count (protocol_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic vec_t rand_vec();
        vec_t v;
        for (int i = 0; i < VEC_LEN; i++)
            v[i] = elem_t'($urandom_range(0, 255));
        return v;
    endfunction

    // Coefficients hit the range limits about half the time
    function automatic vec_t rand_coef_vec();
        vec_t v;
        for (int i = 0; i < VEC_LEN; i++)
        begin
            case ($urandom_range(0, 3))
                0: v[i] = elem_t'(127);
                1: v[i] = elem_t'(-128);
                default: v[i] = elem_t'($urandom_range(0, 255));
            endcase
        end
        return v;
    endfunction

    function automatic vec_t fill_vec(input elem_t e);
        vec_t v;
        for (int i = 0; i < VEC_LEN; i++)
            v[i] = e;
        return v;
    endfunction

    // Output ready is either always high or random in long stretches
    always @(negedge clk)
    begin
        if (!bp_mode)
            out_ready = 1'b1;
        else if (hold_left == 0)
        begin
            out_ready = ($urandom_range(0, 2) == 0);
            hold_left = $urandom_range(1, 24);
        end
        else
            hold_left = hold_left - 1;
    end

    // Called on a falling edge and returns on one
    task automatic send_vector(input ln_in_t v);
        int waited;
        if (timed_out)
            return;
        in_data  = v;
        in_valid = 1'b1;
        waited   = 0;
        while (!in_ready && !timed_out)
        begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                $display("ERROR: timeout, in_ready stayed low for %0d cycles", waited);
                timed_out = 1'b1;
                other_errs++;
            end
        end
        if (!timed_out)
        begin
            @(negedge clk);
            sent_count++;
        end
        in_valid = 1'b0;
    endtask

    // Kind 0 is unit gamma, 1 random affine and 2 constant data
    task automatic send_batch(input int count, input int kind);
        ln_in_t v;
        for (int k = 0; k < count; k++)
        begin
            v.data  = (kind == 2) ? fill_vec(elem_t'($urandom_range(0, 255))) : rand_vec();
            v.gamma = (kind == 0) ? fill_vec(elem_t'(16)) : rand_coef_vec();
            v.beta  = (kind == 0) ? fill_vec(elem_t'(0)) : rand_coef_vec();
            send_vector(v);
            repeat ($urandom_range(0, 3)) @(negedge clk);
        end
    endtask

    initial
    begin
        int waited;
        rst_n      = 1'b0;
        in_valid   = 1'b0;
        in_data    = '0;
        out_ready  = 1'b1;
        bp_mode    = 1'b0;
        hold_left  = 0;
        sent_count = 0;
        other_errs = 0;
        timed_out  = 1'b0;
        void'($urandom(32'h8e1e));

        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (in_ready !== 1'b1)
        begin
            $display("mismatch in_ready after reset: expected %h actual %h", 1'b1, in_ready);
            other_errs++;
        end
        if (out_valid !== 1'b0)
        begin
            $display("mismatch out_valid after reset: expected %h actual %h", 1'b0, out_valid);
            other_errs++;
        end

        send_batch(N_UNIT, 0);
        send_batch(N_AFFINE, 1);
        send_batch(N_CONST, 2);
        bp_mode = 1'b1;
        send_batch(N_BACKPR, 1);

        waited = 0;
        while (checked_count < sent_count && !timed_out)
        begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
            begin
                $display("ERROR: timeout, %0d of %0d results never arrived",
                         sent_count - checked_count, sent_count);
                timed_out = 1'b1;
                other_errs++;
            end
        end
        repeat (2) @(negedge clk);

        $display("Summary: sent %0d, checked %0d, mismatches %0d, protocol errors %0d, other %0d",
                 sent_count, checked_count, mismatch_count, protocol_count, other_errs);
        if (mismatch_count == 0 && protocol_count == 0 && other_errs == 0
            && checked_count == sent_count)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- flist.f
verilog/ln_pkg.sv
verilog/layer_norm_ctrl.sv
verilog/norm_stats.sv
verilog/norm_sqrt.sv
verilog/norm_affine.sv
verilog/layer_norm_top.sv
dv/ln_checker.sv
dv/tb_layer_norm.sv

//--- Makefile
SIM       = verilator
SIM_FLAGS = --binary --timing -Wno-fatal -j 0
TOP       = tb_layer_norm
FLIST     = flist.f
BUILD     = obj_dir
BIN       = $(BUILD)/V$(TOP)
LOG       = sim.log
SRCS      = $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
